//--- verilog/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and register file sizes
`define DATA_W    32
`define REG_AW    5
`define NUM_REGS  32

// instruction field widths
`define OP_W      6
`define FUNCT_W   6
`define SHAMT_W   5
`define IMM_W     16

// low bit of each instruction field
`define OP_LSB    26
`define RS_LSB    21
`define RT_LSB    16
`define RD_LSB    11
`define SHAMT_LSB 6

`endif

//--- verilog/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

   typedef logic [`DATA_W-1:0] data_t;
   typedef logic [`REG_AW-1:0] reg_addr_t;

   // major opcodes kept by the core, anything else is undefined
   typedef enum logic [`OP_W-1:0] {
      OP_RTYPE = 6'd0, OP_ADDI = 6'd8, OP_ADDIU = 6'd9, OP_SLTI = 6'd10,
      OP_ANDI = 6'd12, OP_ORI = 6'd13, OP_XORI = 6'd14, OP_LUI = 6'd15
   } opcode_e;

   // secondary opcode for r-type
   typedef enum logic [`FUNCT_W-1:0] {
      FN_SLL = 6'd0, FN_SRL = 6'd2, FN_SRA = 6'd3, FN_SLLV = 6'd4,
      FN_SRLV = 6'd6, FN_SRAV = 6'd7, FN_ADD = 6'd32, FN_ADDU = 6'd33,
      FN_SUB = 6'd34, FN_SUBU = 6'd35, FN_AND = 6'd36, FN_OR = 6'd37,
      FN_XOR = 6'd38, FN_NOR = 6'd39, FN_SLT = 6'd42, FN_SLTU = 6'd43
   } funct_e;

   // variable shifts reuse the plain shift ops, decode swaps the amount
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

// decoded instruction handed from ID to EX
interface issue_if import core_pkg::*; ();
   logic                valid;
   alu_op_e             alu_op;
   data_t               a;
   data_t               b;
   logic [`SHAMT_W-1:0] shamt;
   reg_addr_t           dest;
   // register write, already cleared for r0 and undefined ops
   logic                we;

   modport decode (output valid, alu_op, a, b, shamt, dest, we);
   modport exec (input valid, alu_op, a, b, shamt, dest, we);
endinterface

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module reg_file import core_pkg::*; (
   input  wire logic      clk,
   input  wire logic      rst_b,
   input  wire reg_addr_t rs_addr,
   input  wire reg_addr_t rt_addr,
   output data_t          rs_data,
   output data_t          rt_data,
   input  wire logic      we,
   input  wire reg_addr_t wr_addr,
   input  wire data_t     wr_data
);

   // r0 has no storage
   data_t regs [1:`NUM_REGS-1];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wr_addr != '0)) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // no write-through, the decode interlock holds readers off
   assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
   assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- verilog/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module inst_decode import core_pkg::*; (
   input  wire logic              clk,
   input  wire logic              rst_b,
   input  wire logic [`DATA_W-1:0] inst,
   input  wire logic              inst_valid,
   output logic                   inst_ready,
   output reg_addr_t              rs_addr,
   output reg_addr_t              rt_addr,
   input  wire data_t             rs_data,
   input  wire data_t             rt_data,
   input  wire logic              ex_valid,
   input  wire reg_addr_t         ex_dest,
   input  wire logic              wb_valid,
   input  wire reg_addr_t         wb_dest,
   issue_if.decode                issue
);

   logic               id_valid;
   logic [`DATA_W-1:0] id_inst;
   opcode_e            op;
   funct_e             fn;
   reg_addr_t          rd;
   logic [`IMM_W-1:0]  imm;
   data_t              imm_ext;
   logic               r_type;
   logic               zext;
   logic               var_shift;
   logic               defined;
   alu_op_e            alu_op;
   logic               rs_hit;
   logic               rt_hit;
   logic               issue_now;

   // ID register, refilled whenever the slot empties this cycle
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         id_valid <= 1'b0;
      end else if (inst_ready) begin
         id_valid <= inst_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (inst_valid && inst_ready) begin
         id_inst <= inst;
      end
   end

   // field split
   assign op      = opcode_e'(id_inst[`OP_LSB +: `OP_W]);
   assign fn      = funct_e'(id_inst[`FUNCT_W-1:0]);
   assign rs_addr = id_inst[`RS_LSB +: `REG_AW];
   assign rt_addr = id_inst[`RT_LSB +: `REG_AW];
   assign rd      = id_inst[`RD_LSB +: `REG_AW];
   assign imm     = id_inst[`IMM_W-1:0];
   assign r_type  = (op == OP_RTYPE);

   always_comb begin
      alu_op    = ALU_ADD;
      zext      = 1'b0;
      var_shift = 1'b0;
      defined   = 1'b1;
      case (op)
         OP_RTYPE: begin
            case (fn)
               FN_ADD, FN_ADDU: alu_op = ALU_ADD;
               FN_SUB, FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLTU: alu_op = ALU_SLTU;
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               FN_SLLV: begin
                  alu_op    = ALU_SLL;
                  var_shift = 1'b1;
               end
               FN_SRLV: begin
                  alu_op    = ALU_SRL;
                  var_shift = 1'b1;
               end
               FN_SRAV: begin
                  alu_op    = ALU_SRA;
                  var_shift = 1'b1;
               end
               default: defined = 1'b0;
            endcase
         end
         OP_ADDI, OP_ADDIU: alu_op = ALU_ADD;
         OP_SLTI: alu_op = ALU_SLT;
         // logical immediates are zero-extended
         OP_ANDI: begin
            alu_op = ALU_AND;
            zext   = 1'b1;
         end
         OP_ORI: begin
            alu_op = ALU_OR;
            zext   = 1'b1;
         end
         OP_XORI: begin
            alu_op = ALU_XOR;
            zext   = 1'b1;
         end
         OP_LUI: begin
            alu_op = ALU_LUI;
            zext   = 1'b1;
         end
         default: defined = 1'b0;
      endcase
   end

   assign imm_ext = zext ? {{(`DATA_W-`IMM_W){1'b0}}, imm}
                         : {{(`DATA_W-`IMM_W){imm[`IMM_W-1]}}, imm};

   // RAW check against writers still in EX or WB, r0 never conflicts
   assign rs_hit = (rs_addr != '0) &&
                   ((ex_valid && (rs_addr == ex_dest)) || (wb_valid && (rs_addr == wb_dest)));
   // rt is only a source for r-type
   assign rt_hit = r_type && (rt_addr != '0) &&
                   ((ex_valid && (rt_addr == ex_dest)) || (wb_valid && (rt_addr == wb_dest)));

   assign issue_now  = id_valid && !(rs_hit || rt_hit);
   assign inst_ready = !id_valid || issue_now;

   // EX always takes what is offered
   assign issue.valid  = issue_now;
   assign issue.alu_op = alu_op;
   assign issue.a      = rs_data;
   assign issue.b      = r_type ? rt_data : imm_ext;
   // variable shifts take the amount from rs
   assign issue.shamt  = var_shift ? rs_data[`SHAMT_W-1:0]
                                   : id_inst[`SHAMT_LSB +: `SHAMT_W];
   assign issue.dest   = r_type ? rd : rt_addr;
   assign issue.we     = defined && (issue.dest != '0);

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_stage import core_pkg::*; (
   input  wire logic clk,
   input  wire logic rst_b,
   issue_if.exec     issue,
   output logic      ex_valid,
   output reg_addr_t ex_dest,
   output logic      wb_valid,
   output reg_addr_t wb_dest,
   output data_t     wb_data
);

   alu_op_e             ex_op;
   data_t               ex_a;
   data_t               ex_b;
   logic [`SHAMT_W-1:0] ex_shamt;
   data_t               alu_res;

   // EX register
   // ex_valid only marks entries that will write, which is all the interlock needs
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= issue.valid && issue.we;
      end
   end

   always_ff @(posedge clk) begin
      if (issue.valid) begin
         ex_op    <= issue.alu_op;
         ex_a     <= issue.a;
         ex_b     <= issue.b;
         ex_shamt <= issue.shamt;
         ex_dest  <= issue.dest;
      end
   end

   // ALU
   always_comb begin
      case (ex_op)
         // add and sub wrap, no overflow trap
         ALU_ADD:  alu_res = ex_a + ex_b;
         ALU_SUB:  alu_res = ex_a - ex_b;
         ALU_AND:  alu_res = ex_a & ex_b;
         ALU_OR:   alu_res = ex_a | ex_b;
         ALU_XOR:  alu_res = ex_a ^ ex_b;
         ALU_NOR:  alu_res = ~(ex_a | ex_b);
         ALU_SLT: begin
            alu_res = ($signed(ex_a) < $signed(ex_b)) ? data_t'(1) : '0;
         end
         ALU_SLTU: begin
            alu_res = (ex_a < ex_b) ? data_t'(1) : '0;
         end
         // shifts move b, amount already picked in decode
         ALU_SLL:  alu_res = ex_b << ex_shamt;
         ALU_SRL:  alu_res = ex_b >> ex_shamt;
         ALU_SRA:  alu_res = data_t'($signed(ex_b) >>> ex_shamt);
         // immediate lands in the upper half
         ALU_LUI:  alu_res = {ex_b[`IMM_W-1:0], {(`DATA_W-`IMM_W){1'b0}}};
         default:  alu_res = ex_a + ex_b;
      endcase
   end

   // WB register, drives both the register file and the top outputs
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= ex_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid) begin
         wb_dest <= ex_dest;
         wb_data <= alu_res;
      end
   end

endmodule

`default_nettype wire

//--- verilog/int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module int_pipe import core_pkg::*; (
   input  wire logic               clk,
   input  wire logic               rst_b,
   input  wire logic [`DATA_W-1:0] inst,
   input  wire logic               inst_valid,
   output logic                    inst_ready,
   output logic                    wb_valid,
   output reg_addr_t               wb_dest,
   output data_t                   wb_data
);

   reg_addr_t rs_addr;
   reg_addr_t rt_addr;
   data_t     rs_data;
   data_t     rt_data;
   logic      ex_valid;
   reg_addr_t ex_dest;

   // decode to execute
   issue_if issue ();

   inst_decode u_decode (
      .clk(clk), .rst_b(rst_b),
      .inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready),
      .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
      .ex_valid(ex_valid), .ex_dest(ex_dest), .wb_valid(wb_valid), .wb_dest(wb_dest),
      .issue(issue.decode)
   );

   // written from WB, read from ID
   reg_file u_regs (
      .clk(clk), .rst_b(rst_b),
      .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
      .we(wb_valid), .wr_addr(wb_dest), .wr_data(wb_data)
   );

   exec_stage u_exec (
      .clk(clk), .rst_b(rst_b), .issue(issue.exec),
      .ex_valid(ex_valid), .ex_dest(ex_dest),
      .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
   );

endmodule

`default_nettype wire

//--- verification/int_pipe_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module int_pipe_assertions import core_pkg::*; (
   input wire logic               clk,
   input wire logic               rst_b,
   input wire logic [`DATA_W-1:0] inst,
   input wire logic               inst_valid,
   input wire logic               inst_ready,
   input wire logic               wb_valid
);

   logic accept_writer;

   // instruction is defined and targets a nonzero register
   function automatic logic writes(input logic [`DATA_W-1:0] w);
      logic [`OP_W-1:0]    op;
      logic [`FUNCT_W-1:0] fn;
      reg_addr_t           dest;
      logic                known;
      op = w[`OP_LSB +: `OP_W];
      fn = w[`FUNCT_W-1:0];
      if (op == OP_RTYPE) begin
         dest  = w[`RD_LSB +: `REG_AW];
         known = fn inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD,
                            FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                            FN_SLT, FN_SLTU};
      end else begin
         dest  = w[`RT_LSB +: `REG_AW];
         known = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
      end
      return known && (dest != '0);
   endfunction

   assign accept_writer = inst_valid && inst_ready && writes(inst);

   // accepted at t, issued at t+1 with no stall, so wb_valid in the cycle after t+2
   a_latency: assert property (@(posedge clk) disable iff (!rst_b)
      ($past(accept_writer, 3) && $past(inst_ready, 2)) |-> wb_valid)
      else $error("write-back missing two cycles after an unstalled issue");

   // a pending instruction is held with the same word
   a_hold_valid: assert property (@(posedge clk) disable iff (!rst_b)
      (inst_valid && !inst_ready) |=> inst_valid)
      else $error("inst_valid dropped before acceptance");

   a_hold_inst: assert property (@(posedge clk) disable iff (!rst_b)
      (inst_valid && !inst_ready) |=> $stable(inst))
      else $error("inst changed before acceptance");

   // first edge out of reset sees an empty pipe
   a_reset: assert property (@(posedge clk) $rose(rst_b) |-> (inst_ready && !wb_valid))
      else $error("pipeline not idle after reset");

endmodule

`default_nettype wire

//--- verification/tb_int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_int_pipe import core_pkg::*; ();

   localparam int n_inst      = 400;
   localparam int wait_cycles = 50;

   logic               clk;
   logic               rst_b;
   logic [`DATA_W-1:0] inst;
   logic               inst_valid;
   logic               inst_ready;
   logic               wb_valid;
   reg_addr_t          wb_dest;
   data_t              wb_data;

   // reference register array and expected writes in retire order
   data_t       model_regs [`NUM_REGS];
   reg_addr_t   exp_dest [$];
   data_t       exp_data [$];
   reg_addr_t   want_dest;
   data_t       want_data;
   logic [31:0] rng;
   logic [31:0] gap_r;
   logic [31:0] next_w;
   int          drain_wait;

   int_pipe i_dut (
      .clk(clk), .rst_b(rst_b), .inst(inst), .inst_valid(inst_valid),
      .inst_ready(inst_ready), .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
   );

   bind int_pipe int_pipe_assertions i_assert (
      .clk(clk), .rst_b(rst_b), .inst(inst), .inst_valid(inst_valid),
      .inst_ready(inst_ready), .wb_valid(wb_valid)
   );

   always #4 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng = xorshift32(rng);
      r   = rng;
   endtask

   // random instruction with registers limited to r0..r7 so dependences are frequent
   task automatic make_inst(output logic [31:0] w);
      logic [31:0] r;
      logic [31:0] sel;
      reg_addr_t   rs;
      reg_addr_t   rt;
      reg_addr_t   rd;
      logic [5:0]  fn_pick [16];
      logic [5:0]  op_pick [8];
      logic [5:0]  bad_fn [4];
      logic [5:0]  bad_op [4];
      fn_pick = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU,
                  FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
      op_pick = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ORI};
      // break, syscall, mfhi and an unused code
      bad_fn  = '{6'd1, 6'd12, 6'd13, 6'd16};
      // j, beq, lw, sw
      bad_op  = '{6'd2, 6'd4, 6'd35, 6'd43};
      next_rand(r);
      next_rand(sel);
      rs = {2'b00, r[6:4]};
      rt = {2'b00, r[9:7]};
      rd = {2'b00, r[12:10]};
      if (sel[3:0] < 4'd9) begin
         w = {OP_RTYPE, rs, rt, rd, r[17:13], fn_pick[sel[7:4]]};
      end else if (sel[3:0] < 4'd14) begin
         w = {op_pick[sel[10:8]], rs, rt, r[31:16]};
      end else if (sel[3:0] == 4'd14) begin
         w = {OP_RTYPE, rs, rt, rd, r[17:13], bad_fn[sel[12:11]]};
      end else begin
         w = {bad_op[sel[12:11]], rs, rt, r[31:16]};
      end
   endtask

   // architectural effect of one instruction under the ISA rules
   task automatic model_apply(input logic [31:0] w);
      logic [5:0]  op;
      logic [5:0]  fn;
      logic [4:0]  sh;
      logic [15:0] imm;
      data_t       a;
      data_t       b;
      data_t       simm;
      data_t       val;
      reg_addr_t   dest;
      logic        ok;
      op   = w[31:26];
      fn   = w[5:0];
      sh   = w[10:6];
      imm  = w[15:0];
      a    = model_regs[w[25:21]];
      b    = model_regs[w[20:16]];
      simm = {{16{imm[15]}}, imm};
      dest = w[20:16];
      val  = '0;
      ok   = 1'b1;
      case (op)
         OP_RTYPE: begin
            dest = w[15:11];
            case (fn)
               FN_ADD, FN_ADDU: val = a + b;
               FN_SUB, FN_SUBU: val = a - b;
               FN_AND:  val = a & b;
               FN_OR:   val = a | b;
               FN_XOR:  val = a ^ b;
               FN_NOR:  val = ~(a | b);
               FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
               FN_SLL:  val = b << sh;
               FN_SRL:  val = b >> sh;
               FN_SRA:  val = $signed(b) >>> sh;
               FN_SLLV: val = b << a[4:0];
               FN_SRLV: val = b >> a[4:0];
               FN_SRAV: val = $signed(b) >>> a[4:0];
               default: ok = 1'b0;
            endcase
         end
         OP_ADDI, OP_ADDIU: val = a + simm;
         OP_SLTI: val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
         OP_ANDI: val = a & {16'h0000, imm};
         OP_ORI:  val = a | {16'h0000, imm};
         OP_XORI: val = a ^ {16'h0000, imm};
         OP_LUI:  val = {imm, 16'h0000};
         default: ok = 1'b0;
      endcase
      // undefined ops and r0 targets retire silently
      if (ok && dest != 5'd0) begin
         model_regs[dest] = val;
         exp_dest.push_back(dest);
         exp_data.push_back(val);
      end
   endtask

   // ready is sampled mid-cycle and the word is held until an edge takes it
   task automatic send_inst(input logic [31:0] w);
      int   waited;
      logic taken;
      waited     = 0;
      taken      = 1'b0;
      inst       = w;
      inst_valid = 1'b1;
      while (!taken) begin
         @(negedge clk);
         taken = inst_ready;
         @(posedge clk);
         #1;
         waited++;
         if (!taken && waited > wait_cycles) begin
            abort_run("timeout: instruction was never accepted by the DUT");
         end
      end
      inst_valid = 1'b0;
      model_apply(w);
   endtask

   // each write-back pulse against the oldest expected write
   always @(negedge clk) begin
      if (rst_b && wb_valid) begin
         a_expected: assert (exp_dest.size() != 0)
            else abort_run($sformatf("FAIL @%0t ns: unexpected write-back to r%0d",
                                     $time, wb_dest));
         want_dest = exp_dest.pop_front();
         want_data = exp_data.pop_front();
         a_value: assert (wb_dest == want_dest && wb_data == want_data)
            else abort_run($sformatf("FAIL @%0t ns: write-back r%0d = %h, expected r%0d = %h",
                                     $time, wb_dest, wb_data, want_dest, want_data));
      end
   end

   initial begin
      clk        = 1'b0;
      rst_b      = 1'b0;
      inst       = '0;
      inst_valid = 1'b0;
      rng        = 32'd78;
      for (int i = 0; i < `NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      repeat (16) @(posedge clk);
      #1;
      rst_b = 1'b1;
      for (int i = 0; i < n_inst; i++) begin
         make_inst(next_w);
         next_rand(gap_r);
         // roughly one in four instructions comes after an idle gap
         if (gap_r[1:0] == 2'b00) begin
            repeat (gap_r[3:2] + 1) begin
               @(posedge clk);
               #1;
            end
         end
         send_inst(next_w);
      end
      drain_wait = 0;
      while (exp_dest.size() != 0) begin
         @(posedge clk);
         #1;
         drain_wait++;
         if (drain_wait > wait_cycles) begin
            abort_run("timeout: expected write-backs never arrived");
         end
      end
      // last accepted op has left WB three edges after issue
      repeat (4) @(posedge clk);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/core_pkg.sv
verilog/issue_if.sv
verilog/reg_file.sv
verilog/inst_decode.sv
verilog/exec_stage.sv
verilog/int_pipe.sv
verification/int_pipe_assertions.sv
verification/tb_int_pipe.sv

//--- Makefile
# Verilator build and run of the int_pipe testbench
TOP := tb_int_pipe

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f tb.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
